// ==== Bender.yml ====
package:
  name: mul_iterative

sources:
  # RTL, compile order matters for the package and interface
  - target: any(rtl, verif)
    files:
      - verilog/mul_pkg.sv
      - verilog/mul_csa_4_2_if.sv
      - verilog/mul_csa_4_2.sv
      - verilog/mul_wallace_tree.sv
      - verilog/mul_iterative.sv
      - verilog/mul_top.sv

  # testbench and bound assertions
  - target: verif
    files:
      - verif/mul_sva.sv
      - verif/mul_tb.sv

// ==== verif/mul_sva.sv ====
// bound into mul_iterative; the latency rule assumes no reset while a product is in flight
`timescale 1ns/1ns
module mul_sva #(
  parameter  int width_p      = 32,
  parameter  int iter_step_p  = 4,
  parameter  int full_sized_p = 1,
  localparam int out_w_lp     = (full_sized_p + 1) * width_p
) (
  input logic                clk_i,
  input logic                reset_internal,
  input logic                v_i,
  input logic                ready_o,
  input logic [out_w_lp-1:0] result_o,
  input logic                v_o,
  input logic                yumi_i,
  input mul_pkg::mul_state_e state_i
);

  import mul_pkg::*;

  localparam int n_lp = iter_count(width_p, iter_step_p);

  int err_cnt = 0;  // polled by the testbench

  // clean handshake one cycle after reset
  a_reset: assert property (@(posedge clk_i) reset_internal |=> ready_o && !v_o)
    else begin
      $error("ready_o or v_o wrong in the cycle after reset");
      err_cnt++;
    end

  // n CAL cycles, ADJ, CPA, then DONE
  a_latency: assert property (@(posedge clk_i) disable iff (reset_internal)
    (v_i && ready_o) |=> (!v_o && !ready_o) [*(n_lp + 2)] ##1 v_o)
    else begin
      $error("v_o did not rise exactly %0d edges after accept", n_lp + 3);
      err_cnt++;
    end

  a_hold: assert property (@(posedge clk_i) disable iff (reset_internal)
    (v_o && !yumi_i) |=> v_o && $stable(result_o))  // back-pressure
    else begin
      $error("result_o or v_o changed before yumi_i");
      err_cnt++;
    end

  a_release: assert property (@(posedge clk_i) disable iff (reset_internal)
    (v_o && yumi_i) |=> ready_o && !v_o)
    else begin
      $error("not back in IDLE the cycle after yumi_i");
      err_cnt++;
    end

  // v_i while busy must not restart anything
  a_busy: assert property (@(posedge clk_i) disable iff (reset_internal)
    (!ready_o && !(v_o && yumi_i)) |=> !ready_o)
    else begin
      $error("ready_o rose while a product was still held");
      err_cnt++;
    end

  // CAL for n_lp cycles then ADJ and CPA
  a_fsm: assert property (@(posedge clk_i) disable iff (reset_internal)
    (v_i && ready_o) |=> (state_i == CAL) [*n_lp] ##1 (state_i == ADJ) ##1 (state_i == CPA))
    else begin
      $error("FSM did not pass through CAL, ADJ and CPA in the expected cycles");
      err_cnt++;
    end

endmodule

bind mul_iterative mul_sva #(
  .width_p      (width_p),
  .iter_step_p  (iter_step_p),
  .full_sized_p (full_sized_p)
) u_sva (
  .clk_i          (clk_i),
  .reset_internal (reset_internal),
  .v_i            (v_i),
  .ready_o        (ready_o),
  .result_o       (result_o),
  .v_o            (v_o),
  .yumi_i         (yumi_i),
  .state_i        (state_r)
);

// ==== verif/mul_tb.sv ====
// drives mul_top at 32x32 with a 64-bit product; needs a simulator with bind and SVA support
`timescale 1ns/1ns
module mul_tb;

  localparam int n_corner_lp   = 5;
  localparam int n_random_lp   = 60;
  localparam int n_prod_lp     = 4 * n_corner_lp * n_corner_lp + n_random_lp + 2;
  localparam int max_cycles_lp = n_prod_lp * 20 + 200;  // 20 cycles covers latency and hold

  logic        clk_i;
  logic        reset_internal;
  logic        v_i;
  logic        ready_o;
  logic [31:0] opa_i;
  logic        opa_signed_i;
  logic [31:0] opb_i;
  logic        opb_signed_i;
  logic [63:0] result_o;
  logic        v_o;
  logic        yumi_i;

  logic [31:0] rng_state = 32'd32;
  int          cycles = 0;
  logic [31:0] corners [n_corner_lp] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000,
                                         32'h7fff_ffff};

  mul_top u_dut (
    .clk_i          (clk_i),
    .reset_internal (reset_internal),
    .v_i            (v_i),
    .ready_o        (ready_o),
    .opa_i          (opa_i),
    .opa_signed_i   (opa_signed_i),
    .opb_i          (opb_i),
    .opb_signed_i   (opb_signed_i),
    .result_o       (result_o),
    .v_o            (v_o),
    .yumi_i         (yumi_i)
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // extend each operand per its flag to 33 bits, keep the low 64 bits
  function automatic logic [63:0] expected_product(input logic [31:0] a, input logic as,
                                                   input logic [31:0] b, input logic bs);
    logic signed [32:0] xa;
    logic signed [32:0] xb;
    logic signed [65:0] p;
    xa = {as & a[31], a};
    xb = {bs & b[31], b};
    p  = xa * xb;
    return p[63:0];
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  // random v_i pulses while the multiplier is busy
  task automatic drive_noise();
    logic [31:0] junk;
    junk  = next_rand();
    v_i   = junk[23];
    opa_i = junk;
    opb_i = ~junk;
  endtask

  task automatic run_product(input logic [31:0] a, input logic as,
                             input logic [31:0] b, input logic bs);
    logic [63:0] exp;
    int          hold;
    exp  = expected_product(a, as, b, bs);
    hold = (next_rand() >> 16) % 7;
    while (!ready_o) begin
      @(negedge clk_i);
    end
    opa_i        = a;
    opa_signed_i = as;
    opb_i        = b;
    opb_signed_i = bs;
    v_i          = 1'b1;
    @(negedge clk_i);
    v_i = 1'b0;
    while (!v_o) begin
      drive_noise();
      @(negedge clk_i);
    end
    assert (result_o === exp)
      else abort_run($sformatf("[FAIL] %0t ns: %h (s=%0b) * %h (s=%0b) gave %h, expected %h",
                               $time, a, as, b, bs, result_o, exp));
    repeat (hold) begin
      drive_noise();
      @(negedge clk_i);
    end
    v_i    = 1'b0;
    yumi_i = 1'b1;
    @(negedge clk_i);
    yumi_i = 1'b0;
  endtask

  // start a product, then pull reset before it finishes
  task automatic reset_mid_product();
    while (!ready_o) begin
      @(negedge clk_i);
    end
    opa_i = next_rand();
    opb_i = next_rand();
    v_i   = 1'b1;
    @(negedge clk_i);
    v_i = 1'b0;
    repeat (5) @(negedge clk_i);
    reset_internal = 1'b1;
    @(negedge clk_i);
    reset_internal = 1'b0;
  endtask

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles_lp) begin
      abort_run("timeout: the multiplier gave no result within the cycle limit");
    end
  end

  always @(negedge clk_i) begin
    if (u_dut.u_mul.u_sva.err_cnt != 0) begin
      abort_run("a bound handshake or timing assertion failed");
    end
  end

  initial begin
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] rf;
    clk_i          = 1'b0;
    reset_internal = 1'b1;
    v_i            = 1'b0;
    opa_i          = '0;
    opa_signed_i   = 1'b0;
    opb_i          = '0;
    opb_signed_i   = 1'b0;
    yumi_i         = 1'b0;
    repeat (3) @(negedge clk_i);
    reset_internal = 1'b0;

    // corners under all four signedness combinations
    for (int f = 0; f < 4; f++) begin
      for (int i = 0; i < n_corner_lp; i++) begin
        for (int j = 0; j < n_corner_lp; j++) begin
          run_product(corners[i], f[0], corners[j], f[1]);
        end
      end
    end

    for (int k = 0; k < n_random_lp; k++) begin
      ra = next_rand();
      rb = next_rand();
      rf = next_rand();
      run_product(ra, rf[20], rb, rf[27]);  // upper LCG bits
    end

    reset_mid_product();
    ra = next_rand();
    rb = next_rand();
    run_product(ra, 1'b1, rb, 1'b0);  // fresh product after the second reset

    if (u_dut.u_mul.u_sva.err_cnt != 0) begin
      abort_run("a bound handshake or timing assertion failed");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== verilog/mul_csa_4_2.sv ====
// purely combinational, carries out of the top bit are dropped (exact for in-range products)
`timescale 1ns/1ns
module mul_csa_4_2 #(
  parameter  int width_p      = 32,
  parameter  int iter_step_p  = 4,
  parameter  int full_sized_p = 1,
  localparam int csa_w_lp     = width_p + full_sized_p * iter_step_p
) (
  mul_csa_4_2_if.consumer csa_if
);

  import mul_pkg::*;

  csa_pair_t lvl1;  // a + b + c
  csa_pair_t lvl2;  // folds d in

  // first row
  assign lvl1 = csa_3_2(csa_max_w_lp'(csa_if.a_i),
                        csa_max_w_lp'(csa_if.b_i),
                        csa_max_w_lp'(csa_if.c_i));

  // second row takes the shifted carry of the first
  assign lvl2 = csa_3_2(lvl1.sum,
                        lvl1.carry,
                        csa_max_w_lp'(csa_if.d_i));

  // bits above csa_w_lp never feed lower bits
  assign csa_if.sum_o   = lvl2.sum[csa_w_lp-1:0];
  assign csa_if.carry_o = lvl2.carry[csa_w_lp-1:0];

endmodule

// ==== verilog/mul_csa_4_2_if.sv ====
// width_p is the compressor word width, width_p + iter_step_p of the multiplier in full mode
`timescale 1ns/1ns
interface mul_csa_4_2_if #(
  parameter int width_p = 36
);

  logic [width_p-1:0] a_i;      // tree sum or inverted sign term
  logic [width_p-1:0] b_i;      // tree carry or the +1 of negation
  logic [width_p-1:0] c_i;      // remnant sum
  logic [width_p-1:0] d_i;      // remnant carry
  logic [width_p-1:0] sum_o;
  logic [width_p-1:0] carry_o;  // weighted as stored, bit 0 always zero

  // side that owns the datapath
  modport producer (
    output a_i, b_i, c_i, d_i,
    input  sum_o, carry_o
  );

  modport consumer (
    input  a_i, b_i, c_i, d_i,
    output sum_o, carry_o
  );

endinterface

// ==== verilog/mul_iterative.sv ====
// iter_step_p must divide width_p; one product in flight, result held until yumi_i
`timescale 1ns/1ns
module mul_iterative #(
  parameter  int width_p      = 32,
  parameter  int iter_step_p  = 4,
  parameter  int full_sized_p = 1,
  localparam int out_w_lp     = (full_sized_p + 1) * width_p
) (
  input  logic                clk_i,
  input  logic                reset_internal,
  input  logic                v_i,
  output logic                ready_o,
  input  logic [width_p-1:0]  opa_i,
  input  logic                opa_signed_i,
  input  logic [width_p-1:0]  opb_i,
  input  logic                opb_signed_i,
  output logic [out_w_lp-1:0] result_o,
  output logic                v_o,
  input  logic                yumi_i
);

  import mul_pkg::*;

  localparam int n_lp     = iter_count(width_p, iter_step_p);
  localparam int cnt_w_lp = cnt_width(n_lp);
  localparam int csa_w_lp = width_p + full_sized_p * iter_step_p;

  mul_state_e state_r, state_n;
  logic [cnt_w_lp-1:0] cnt_r;   // CAL cycle index

  logic accept;
  logic done_clear;
  logic cal_first;
  logic cal_last;

  assign accept     = v_i & ready_o;
  assign done_clear = reset_internal | (yumi_i & (state_r == DONE));
  assign cal_first  = (cnt_r == '0);
  assign cal_last   = (cnt_r == cnt_w_lp'(n_lp - 1));

  always_comb begin
    unique case (state_r)
      IDLE:    state_n = accept ? CAL : IDLE;
      CAL:     state_n = cal_last ? ADJ : CAL;
      ADJ:     state_n = CPA;
      CPA:     state_n = DONE;
      DONE:    state_n = DONE;  // wait for yumi_i
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (done_clear) begin
      state_r <= IDLE;
      cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      if (state_r == CAL) begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
  end

  assign ready_o = (state_r == IDLE);
  assign v_o     = (state_r == DONE);

  // operands
  logic [width_p-1:0] opa_r;
  logic [width_p-1:0] opb_r;       // shifts down a stride per CAL cycle
  logic               opa_neg_r;
  logic               opb_neg_r;
  logic [width_p-1:0] sign_mod_r;  // amount to subtract from the high half

  // carry-propagate adder
  logic [width_p-1:0] cpa_a;
  logic [width_p-1:0] cpa_b;
  logic [width_p:0]   cpa_sum;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      opa_r     <= opa_i;
      opb_r     <= opb_i;
      opa_neg_r <= opa_signed_i & opa_i[width_p-1];
      opb_neg_r <= opb_signed_i & opb_i[width_p-1];
    end else if (state_r == CAL) begin
      opb_r <= opb_r >> iter_step_p;
      if (cal_first) begin
        sign_mod_r <= cpa_sum[width_p-1:0];  // adder is free in the first cycle
      end
    end
  end

  // low bits waiting for the adder, and the unresolved upper part
  logic [iter_step_p-1:0] low_sum_r;
  logic [iter_step_p-1:0] low_carry_r;
  logic [width_p-1:0]     rem_sum_r;
  logic [width_p-1:0]     rem_carry_r;
  logic [width_p-1:0]     result_low_r;
  logic [width_p-1:0]     low_shift;

  always_comb begin
    cpa_a = '0;
    cpa_b = '0;
    unique case (state_r)
      CAL: begin
        if (cal_first) begin
          cpa_a = opa_r & {width_p{opb_neg_r}};
          cpa_b = opb_r & {width_p{opa_neg_r}};
        end else begin
          cpa_a = width_p'(low_sum_r);
          cpa_b = width_p'(low_carry_r);
        end
      end
      ADJ: begin
        cpa_a = width_p'(low_sum_r);  // last low slice
        cpa_b = width_p'(low_carry_r);
      end
      CPA: begin
        cpa_a = rem_sum_r;
        cpa_b = rem_carry_r;
      end
      default: begin
      end
    endcase
  end

  assign cpa_sum = cpa_a + cpa_b;

  // resolved bits enter at the top, first slice is shifted out again
  assign low_shift = (result_low_r >> iter_step_p)
                   | (width_p'(cpa_sum[iter_step_p-1:0]) << (width_p - iter_step_p));

  // partial products for this stride
  logic [iter_step_p-1:0][csa_w_lp-1:0] pp;
  logic [csa_w_lp-1:0] tree_sum;
  logic [csa_w_lp-1:0] tree_carry;

  for (genvar i = 0; i < iter_step_p; i++) begin : g_pp
    assign pp[i] = csa_w_lp'(opa_r & {width_p{opb_r[i]}}) << i;
  end

  mul_wallace_tree #(
    .width_p      (width_p),
    .iter_step_p  (iter_step_p),
    .full_sized_p (full_sized_p)
  ) u_tree (
    .pp_i    (pp),
    .sum_o   (tree_sum),
    .carry_o (tree_carry)
  );

  mul_csa_4_2_if #(.width_p(csa_w_lp)) csa_if ();

  logic [csa_w_lp-1:0] csa_a;
  logic [csa_w_lp-1:0] csa_b;
  logic [csa_w_lp-1:0] csa_sum;
  logic [csa_w_lp-1:0] csa_carry;

  always_comb begin
    unique case (state_r)
      CAL: begin
        csa_a = tree_sum;
        csa_b = tree_carry;
      end
      ADJ: begin
        csa_a = ~csa_w_lp'(sign_mod_r);  // two's complement of the sign term
        csa_b = csa_w_lp'(1);
      end
      default: begin
        csa_a = '0;
        csa_b = '0;
      end
    endcase
  end

  assign csa_if.a_i = csa_a;
  assign csa_if.b_i = csa_b;
  assign csa_if.c_i = csa_w_lp'(rem_sum_r);
  assign csa_if.d_i = csa_w_lp'(rem_carry_r);
  assign csa_sum    = csa_if.sum_o;
  assign csa_carry  = csa_if.carry_o;

  mul_csa_4_2 #(
    .width_p      (width_p),
    .iter_step_p  (iter_step_p),
    .full_sized_p (full_sized_p)
  ) u_csa (
    .csa_if (csa_if.consumer)
  );

  always_ff @(posedge clk_i) begin
    if (done_clear) begin
      low_sum_r    <= '0;
      low_carry_r  <= '0;
      rem_sum_r    <= '0;
      rem_carry_r  <= '0;
      result_low_r <= '0;
    end else begin
      unique case (state_r)
        CAL: begin
          result_low_r <= low_shift;
          low_sum_r    <= csa_sum[iter_step_p-1:0];
          // carry out of the previous slice lands in bit 0
          low_carry_r  <= csa_carry[iter_step_p-1:0]
                        | iter_step_p'(cpa_sum[iter_step_p] & ~cal_first);
          rem_sum_r    <= width_p'(csa_sum >> iter_step_p);
          rem_carry_r  <= width_p'(csa_carry >> iter_step_p);
        end
        ADJ: begin
          result_low_r <= low_shift;
          rem_sum_r    <= csa_sum[width_p-1:0];
          rem_carry_r  <= csa_carry[width_p-1:0] | width_p'(cpa_sum[iter_step_p]);
        end
        CPA: begin
          rem_sum_r <= cpa_sum[width_p-1:0];  // high half resolved
        end
        default: begin
        end
      endcase
    end
  end

  if (full_sized_p != 0) begin : g_full
    assign result_o = {rem_sum_r, result_low_r};
  end else begin : g_half
    assign result_o = result_low_r;
  end

endmodule

// ==== verilog/mul_pkg.sv ====
// csa_3_2 works on words up to csa_max_w_lp bits, so width_p + iter_step_p must not exceed it
package mul_pkg;

  // multiplier FSM
  typedef enum logic [2:0] {
    IDLE,
    CAL,
    ADJ,
    CPA,
    DONE
  } mul_state_e;

  localparam int csa_max_w_lp = 128;  // widest word the 3:2 helper handles

  typedef struct packed {
    logic [csa_max_w_lp-1:0] sum;
    logic [csa_max_w_lp-1:0] carry;  // already shifted up by one
  } csa_pair_t;

  // number of CAL cycles, stride must divide width
  function automatic int iter_count(input int width, input int stride);
    return width / stride;
  endfunction

  // counter width, never below one bit
  function automatic int cnt_width(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  // one row of full adders, narrower callers pass zero-extended words
  function automatic csa_pair_t csa_3_2(input logic [csa_max_w_lp-1:0] x,
                                        input logic [csa_max_w_lp-1:0] y,
                                        input logic [csa_max_w_lp-1:0] z);
    csa_pair_t r;
    r.sum   = x ^ y ^ z;
    r.carry = ((x & y) | (x & z) | (y & z)) << 1;
    return r;
  endfunction

endpackage

// ==== verilog/mul_top.sv ====
// 32x32 multiply with stride 4 and 64-bit product, v_o rises 11 edges after accept
`timescale 1ns/1ns
module mul_top #(
  parameter  int width_p      = 32,
  parameter  int iter_step_p  = 4,
  parameter  int full_sized_p = 1,
  localparam int out_w_lp     = (full_sized_p + 1) * width_p
) (
  input  logic                clk_i,
  input  logic                reset_internal,  // sync, active high

  // operand side
  input  logic                v_i,
  output logic                ready_o,
  input  logic [width_p-1:0]  opa_i,
  input  logic                opa_signed_i,
  input  logic [width_p-1:0]  opb_i,
  input  logic                opb_signed_i,

  // product side
  output logic [out_w_lp-1:0] result_o,
  output logic                v_o,
  input  logic                yumi_i           // only while v_o is high
);

  mul_iterative #(
    .width_p      (width_p),
    .iter_step_p  (iter_step_p),
    .full_sized_p (full_sized_p)
  ) u_mul (
    .clk_i          (clk_i),
    .reset_internal (reset_internal),
    .v_i            (v_i),
    .ready_o        (ready_o),
    .opa_i          (opa_i),
    .opa_signed_i   (opa_signed_i),
    .opb_i          (opb_i),
    .opb_signed_i   (opb_signed_i),
    .result_o       (result_o),
    .v_o            (v_o),
    .yumi_i         (yumi_i)
  );

endmodule

// ==== verilog/mul_wallace_tree.sv ====
// inputs are non-negative partial products whose total fits in csa_w_lp bits (full mode)
`timescale 1ns/1ns
module mul_wallace_tree #(
  parameter  int width_p      = 32,
  parameter  int iter_step_p  = 4,
  parameter  int full_sized_p = 1,
  localparam int csa_w_lp     = width_p + full_sized_p * iter_step_p
) (
  input  logic [iter_step_p-1:0][csa_w_lp-1:0] pp_i,
  output logic [csa_w_lp-1:0]                  sum_o,
  output logic [csa_w_lp-1:0]                  carry_o
);

  import mul_pkg::*;

  // words left after lvl layers of 3:2
  function automatic int words_after(input int n, input int lvl);
    int w;
    w = n;
    for (int i = 0; i < lvl; i++) begin
      w = (w > 2) ? 2 * (w / 3) + (w % 3) : w;
    end
    return w;
  endfunction

  // layers needed to get down to two words
  function automatic int tree_depth(input int n);
    int w;
    int d;
    w = n;
    d = 0;
    while (w > 2) begin
      w = 2 * (w / 3) + (w % 3);
      d++;
    end
    return d;
  endfunction

  localparam int depth_lp = tree_depth(iter_step_p);

  logic [csa_w_lp-1:0] layer [depth_lp+1][iter_step_p];

  for (genvar i = 0; i < iter_step_p; i++) begin : g_in
    assign layer[0][i] = pp_i[i];
  end

  for (genvar l = 0; l < depth_lp; l++) begin : g_lvl
    localparam int n_in_lp  = words_after(iter_step_p, l);
    localparam int n_grp_lp = n_in_lp / 3;
    localparam int n_out_lp = words_after(iter_step_p, l + 1);

    // full groups of three become sum/carry pairs
    for (genvar g = 0; g < n_grp_lp; g++) begin : g_csa
      csa_pair_t pair;
      assign pair = csa_3_2(csa_max_w_lp'(layer[l][3*g]),
                            csa_max_w_lp'(layer[l][3*g+1]),
                            csa_max_w_lp'(layer[l][3*g+2]));
      assign layer[l+1][2*g]   = pair.sum[csa_w_lp-1:0];
      assign layer[l+1][2*g+1] = pair.carry[csa_w_lp-1:0];
    end

    for (genvar r = 0; r < n_in_lp % 3; r++) begin : g_pass
      assign layer[l+1][2*n_grp_lp+r] = layer[l][3*n_grp_lp+r];  // leftovers skip a layer
    end

    for (genvar k = n_out_lp; k < iter_step_p; k++) begin : g_zero
      assign layer[l+1][k] = '0;
    end
  end

  if (iter_step_p == 1) begin : g_single
    assign sum_o   = layer[0][0];  // lone product, nothing to compress
    assign carry_o = '0;
  end else begin : g_pair
    assign sum_o   = layer[depth_lp][0];
    assign carry_o = layer[depth_lp][1];
  end

endmodule

// ==== vlog.f ====
verilog/mul_pkg.sv
verilog/mul_csa_4_2_if.sv
verilog/mul_csa_4_2.sv
verilog/mul_wallace_tree.sv
verilog/mul_iterative.sv
verilog/mul_top.sv
verif/mul_sva.sv
verif/mul_tb.sv
